//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

   // Field split of one instruction word
   // Type A uses rb and alt, type B reads rb and alt as imm16
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] alt;
   } instFields;

   // Prefix and return
   localparam logic [5:0] opImm  = 6'o54;
   localparam logic [5:0] opRtd  = 6'o55;

   // Unconditional branch, register and immediate forms
   localparam logic [5:0] opBru  = 6'o46;
   localparam logic [5:0] opBrui = 6'o56;

   // Conditional branch, register and immediate forms
   localparam logic [5:0] opBcc  = 6'o47;
   localparam logic [5:0] opBcci = 6'o57;

   // Two-cycle units
   localparam logic [5:0] opMul  = 6'o20;
   localparam logic [5:0] opMuli = 6'o30;
   localparam logic [5:0] opBsf  = 6'o21;
   localparam logic [5:0] opBsfi = 6'o31;

   // Memory ops, matched on opcode bits 5, 4 and 2
   localparam logic [2:0] loadPattern  = 3'o6;
   localparam logic [2:0] storePattern = 3'o7;

   // Vector instructions, branch and link to fixed addresses
   localparam logic [31:0] intVectorOp = 32'hB9CE0010;
   localparam logic [31:0] excVectorOp = 32'hBA2D0008;
   localparam logic [31:0] brkVectorOp = 32'hBA0C0018;

   function automatic logic isBranchOp(input logic [5:0] op);
      return (op == opBru) || (op == opBrui);
   endfunction

   function automatic logic isCondOp(input logic [5:0] op);
      return (op == opBcc) || (op == opBcci);
   endfunction

   function automatic logic isMulOp(input logic [5:0] op);
      return (op == opMul) || (op == opMuli);
   endfunction

   function automatic logic isBsfOp(input logic [5:0] op);
      return (op == opBsf) || (op == opBsfi);
   endfunction

   function automatic logic isLoadOp(input logic [5:0] op);
      return {op[5:4], op[2]} == loadPattern;
   endfunction

   function automatic logic isStoreOp(input logic [5:0] op);
      return {op[5:4], op[2]} == storePattern;
   endfunction

endpackage

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none

package pipePkg;

   // Operation class seen by execute
   // alu is zero so a cleared bundle reads as a NOP
   typedef enum logic [3:0] {
      alu,
      immPrefix,
      branch,
      condBranch,
      ret,
      load,
      store,
      mul,
      bsf
   } opClass;

   // Word held in the instruction buffer
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm16;
      logic [31:0] simm;
      // Set when the interrupt vector took this slot
      logic        isInt;
   } bufInst;

   // Decoded bundle handed to execute
   typedef struct packed {
      opClass      cls;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [31:0] simm;
      logic        writeEn;
      logic        isInt;
      logic [31:0] pc;
   } decBundle;

endpackage

`default_nettype wire

//--- design/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
   parameter logic [31:0] resetVector = 32'h0
) (
   input  wire         gclk,
   input  wire         grst,
   input  wire         gena,
   input  wire         branchTaken,
   input  wire  [31:0] branchTarget,
   output logic [31:0] instAddr,
   output logic        instEn,
   output logic [31:0] fetchPc
);

   // Address of the word now on the instruction bus
   logic [31:0] addrDly;

   // Memory runs with the pipeline
   assign instEn = gena;

   // Program counter
   always_ff @(posedge gclk) begin
      if (grst) begin
         instAddr <= resetVector;
      end else if (gena) begin
         // Redirect wins over the sequential step
         if (branchTaken) begin
            instAddr <= branchTarget;
         end else begin
            instAddr <= instAddr + 32'd4;
         end
      end
   end

   // Pc delay line
   // First stage matches the registered memory read
   // Second stage matches the buffer register
   always_ff @(posedge gclk) begin
      if (grst) begin
         addrDly <= resetVector;
         fetchPc <= resetVector;
      end else if (gena) begin
         addrDly <= instAddr;
         fetchPc <= addrDly;
      end
   end

endmodule

`default_nettype wire

//--- instBuffer/instBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module instBuffer import isaPkg::*, pipePkg::*; (
   input  wire         gclk,
   input  wire         grst,
   input  wire         gena,
   input  wire         oena,
   input  wire         msrIe,
   input  wire         intReq,
   input  wire  [31:0] instData,
   output bufInst      ibuf,
   output logic        stall
);

   // Interrupt sampling
   logic        intSample;
   logic        intLatch;

   // Delay-slot guard
   logic        heldImm;
   logic        slotBlocked;
   logic        insertInt;

   // Selected word and its immediate
   logic [31:0] selWord;
   instFields   selFields;
   logic [31:0] selSimm;

   // Stall source
   logic        multiCycle;

   // Interrupt debounce and latch
   // Runs every cycle so pipeline holds do not lose a request
   always_ff @(posedge gclk) begin
      if (grst) begin
         intSample <= 1'b0;
         intLatch  <= 1'b0;
      end else begin
         // Request only sampled while enabled
         if (msrIe) begin
            intSample <= intReq;
         end
         // Sticky until interrupts get disabled
         intLatch <= (intLatch | intSample) & msrIe;
      end
   end

   // Held word is the one just before the slot being filled
   assign heldImm = (ibuf.opcode == opImm);

   // No vector right after a prefix, a return or any branch
   // Those need their next word untouched
   assign slotBlocked = heldImm
                      | (ibuf.opcode == opRtd)
                      | isBranchOp(ibuf.opcode)
                      | isCondOp(ibuf.opcode);

   assign insertInt = intLatch & ~slotBlocked;

   // Vector replaces the fetched word
   assign selWord   = insertInt ? intVectorOp : instData;
   assign selFields = instFields'(selWord);

   // Immediate builder
   // After IMM the upper half comes from the prefix
   always_comb begin
      if (heldImm) begin
         selSimm = {ibuf.imm16, instData[15:0]};
      end else begin
         selSimm = {{16{selWord[15]}}, selWord[15:0]};
      end
   end

   // Buffer register, one enabled edge of latency
   always_ff @(posedge gclk) begin
      if (grst) begin
         ibuf <= '0;
      end else if (gena) begin
         ibuf.opcode <= selFields.opcode;
         ibuf.rd     <= selFields.rd;
         ibuf.ra     <= selFields.ra;
         // rb and alt kept together as the raw low half
         ibuf.imm16  <= {selFields.rb, selFields.alt};
         ibuf.simm   <= selSimm;
         ibuf.isInt  <= insertInt;
      end
   end

   // Multi-cycle ops seen on the word being selected
   assign multiCycle = isMulOp(selFields.opcode)
                     | isBsfOp(selFields.opcode)
                     | isLoadOp(selFields.opcode)
                     | isStoreOp(selFields.opcode);

   // Stall generator
   // One cycle only, never back to back
   always_ff @(posedge gclk) begin
      if (grst) begin
         stall <= 1'b0;
      end else if (!oena) begin
         stall <= ~stall & multiCycle;
      end else begin
         // Operands ready, nothing to wait for
         stall <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- design/opDecode.sv
`timescale 1ns/1ps
`default_nettype none

module opDecode import isaPkg::*, pipePkg::*; (
   input  wire         gclk,
   input  wire         grst,
   input  wire         gena,
   input  wire bufInst ibuf,
   input  wire  [31:0] fetchPc,
   output decBundle    dec
);

   // Next bundle fields
   opClass     nextClass;
   logic [4:0] nextRb;
   logic       noWrite;
   logic       nextWriteEn;

   // Opcode classifier
   // Specific opcodes first, pattern matches for memory last
   always_comb begin
      if (ibuf.opcode == opImm) begin
         nextClass = immPrefix;
      end else if (ibuf.opcode == opRtd) begin
         nextClass = ret;
      end else if (isBranchOp(ibuf.opcode)) begin
         nextClass = branch;
      end else if (isCondOp(ibuf.opcode)) begin
         nextClass = condBranch;
      end else if (isMulOp(ibuf.opcode)) begin
         nextClass = mul;
      end else if (isBsfOp(ibuf.opcode)) begin
         nextClass = bsf;
      end else if (isLoadOp(ibuf.opcode)) begin
         nextClass = load;
      end else if (isStoreOp(ibuf.opcode)) begin
         nextClass = store;
      end else begin
         nextClass = alu;
      end
   end

   // rb sits in the top of the low half
   assign nextRb = ibuf.imm16[15:11];

   // Classes with no register result
   assign noWrite = (nextClass == store)
                  | (nextClass == branch)
                  | (nextClass == condBranch)
                  | (nextClass == ret)
                  | (nextClass == immPrefix);

   // r0 is hardwired, never written
   assign nextWriteEn = ~noWrite & (ibuf.rd != 5'd0);

   // Decode register, one enabled edge of latency
   // Cleared bundle is an alu NOP with no writeback
   always_ff @(posedge gclk) begin
      if (grst) begin
         dec <= '0;
      end else if (gena) begin
         dec.cls     <= nextClass;
         dec.rd      <= ibuf.rd;
         dec.ra      <= ibuf.ra;
         dec.rb      <= nextRb;
         dec.simm    <= ibuf.simm;
         dec.writeEn <= nextWriteEn;
         dec.isInt   <= ibuf.isInt;
         // Pc already lined up with the buffered word
         dec.pc      <= fetchPc;
      end
   end

endmodule

`default_nettype wire

//--- design/frontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module frontEnd import pipePkg::*; #(
   parameter logic [31:0] resetVector = 32'h0
) (
   input  wire         gclk,
   input  wire         grst,
   input  wire         gena,
   input  wire         oena,
   input  wire         intReq,
   input  wire         msrIe,
   input  wire         branchTaken,
   input  wire  [31:0] branchTarget,
   output logic [31:0] instAddr,
   output logic        instEn,
   input  wire  [31:0] instData,
   output logic        stall,
   output decBundle    dec
);

   // Pc aligned with the buffered word
   logic [31:0] fetchPc;

   // Buffer to decode
   bufInst      ibuf;

   // Program counter and bus driver
   fetchUnit #(
      .resetVector (resetVector)
   ) fetchUnit_i (
      .gclk         (gclk),
      .grst         (grst),
      .gena         (gena),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .instAddr     (instAddr),
      .instEn       (instEn),
      .fetchPc      (fetchPc)
   );

   // Word capture, interrupt insertion and stall
   instBuffer instBuffer_i (
      .gclk     (gclk),
      .grst     (grst),
      .gena     (gena),
      .oena     (oena),
      .msrIe    (msrIe),
      .intReq   (intReq),
      .instData (instData),
      .ibuf     (ibuf),
      .stall    (stall)
   );

   // Bundle for execute
   opDecode opDecode_i (
      .gclk    (gclk),
      .grst    (grst),
      .gena    (gena),
      .ibuf    (ibuf),
      .fetchPc (fetchPc),
      .dec     (dec)
   );

endmodule

`default_nettype wire

//--- test/frontEndChecker.sv
`timescale 1ns/1ps
`default_nettype none

module frontEndChecker import pipePkg::*; #(
   parameter logic [31:0] resetVector = 32'h0
) (
   input  wire           gclk,
   input  wire           grst,
   input  wire           gena,
   input  wire           oena,
   input  wire           intReq,
   input  wire           msrIe,
   input  wire           branchTaken,
   input  wire  [31:0]   branchTarget,
   input  wire  [31:0]   instAddr,
   input  wire           instEn,
   input  wire  [31:0]   instData,
   input  wire           stall,
   input  wire decBundle dec
);

   // Counters read by the testbench
   integer errCount = 0;
   integer checkCount = 0;
   integer testErrs = 0;
   integer intSeen = 0;
   // Vectors seen leaving the decode register
   integer intOut = 0;
   integer immSeen = 0;
   integer stallSeen = 0;
   logic   primed = 1'b0;

   // Reference state of pc pipe, latch, buffer, stall and bundle
   logic [31:0] pcNext;
   logic [31:0] pcMem;
   logic [31:0] pcBuf;
   logic        sample;
   logic        latchSet;
   logic        stallExp;
   logic        stallPrev;
   logic [31:0] bufWord;
   logic [31:0] bufSimm;
   logic        bufInt;
   decBundle    decExp;

   // Opcode table of the ISA
   function automatic opClass classOf(input logic [5:0] op);
      if (op == 6'o54) return immPrefix;
      if (op == 6'o55) return ret;
      if (op == 6'o46 || op == 6'o56) return branch;
      if (op == 6'o47 || op == 6'o57) return condBranch;
      if (op == 6'o20 || op == 6'o30) return mul;
      if (op == 6'o21 || op == 6'o31) return bsf;
      // Memory ops by bits 5, 4 and 2
      if ({op[5:4], op[2]} == 3'b110) return load;
      if ({op[5:4], op[2]} == 3'b111) return store;
      return alu;
   endfunction

   task automatic compareValue(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
      checkCount++;
      if (exp !== got) begin
         errCount++;
         testErrs++;
         $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
      end
   endtask

   task automatic noteFailure(input string msg);
      errCount++;
      testErrs++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   task automatic endTest(input string name);
      $display("test %s: %s, %0d errors", name, (testErrs == 0) ? "ok" : "failed", testErrs);
      testErrs = 0;
   endtask

   always @(posedge gclk) begin : modelStep
      opClass      heldCls;
      opClass      selCls;
      logic        insert;
      logic [31:0] word;
      logic [31:0] simm;
      // Outputs are pre-edge values here
      if (primed) begin
         compareValue("instAddr", pcNext, instAddr);
         compareValue("instEn", gena, instEn);
         compareValue("stall", stallExp, stall);
         compareValue("dec", decExp, dec);
         if (stall && stallPrev) begin
            noteFailure("stall stayed high for two cycles in a row");
         end
         // Each bundle counted once as it moves on
         if (gena && dec.isInt) intOut++;
      end
      stallPrev = stall;
      if (grst) begin
         primed    = 1'b1;
         pcNext    = resetVector;
         pcMem     = resetVector;
         pcBuf     = resetVector;
         sample    = 1'b0;
         latchSet  = 1'b0;
         stallExp  = 1'b0;
         stallPrev = 1'b0;
         bufWord   = '0;
         bufSimm   = '0;
         bufInt    = 1'b0;
         decExp    = '0;
      end else begin
         heldCls = classOf(bufWord[31:26]);
         // No vector behind prefix, return or branch
         insert = latchSet && !(heldCls == immPrefix || heldCls == ret
                                || heldCls == branch || heldCls == condBranch);
         word = insert ? 32'hB9CE0010 : instData;
         if (heldCls == immPrefix) begin
            simm = {bufWord[15:0], instData[15:0]};
         end else begin
            simm = {{16{word[15]}}, word[15:0]};
         end
         selCls = classOf(word[31:26]);
         stallExp = !oena && !stallExp
                    && (selCls == mul || selCls == bsf || selCls == load || selCls == store);
         if (stallExp) stallSeen++;
         if (gena) begin
            decExp.cls     = heldCls;
            decExp.rd      = bufWord[25:21];
            decExp.ra      = bufWord[20:16];
            decExp.rb      = bufWord[15:11];
            decExp.simm    = bufSimm;
            decExp.writeEn = (bufWord[25:21] != 5'd0)
                             && !(heldCls == store || heldCls == branch
                                  || heldCls == condBranch || heldCls == ret
                                  || heldCls == immPrefix);
            decExp.isInt   = bufInt;
            decExp.pc      = pcBuf;
            if (heldCls == immPrefix) immSeen++;
            if (insert) intSeen++;
            bufWord = word;
            bufSimm = simm;
            bufInt  = insert;
            // Pc follows its word through memory and buffer
            pcBuf  = pcMem;
            pcMem  = pcNext;
            pcNext = branchTaken ? branchTarget : pcNext + 32'd4;
         end
         // Latch uses the old sample two edges after request
         latchSet = (latchSet || sample) && msrIe;
         if (msrIe) sample = intReq;
      end
   end

endmodule

`default_nettype wire

//--- test/frontEndTb.sv
`timescale 1ns/1ps
`default_nettype none

module frontEndTb import pipePkg::*; ();

   localparam logic [31:0] bootAddr = 32'h0000_0100;

   logic        gclk;
   logic        grst;
   logic        gena;
   logic        oena;
   logic        intReq;
   logic        msrIe;
   logic        branchTaken;
   logic [31:0] branchTarget;
   logic [31:0] instAddr;
   logic        instEn;
   logic [31:0] instData;
   logic        stall;
   decBundle    dec;

   integer      seed = 32'h1d0ff3fe;
   integer      count;
   integer      snap;

   // Small instruction memory aliased by address bits 9..2
   logic [31:0] memWords [0:255];

   frontEnd #(.resetVector(bootAddr)) frontEnd_i (.*);

   frontEndChecker #(.resetVector(bootAddr)) check_i (.*);

   initial begin
      gclk = 1'b0;
      forever #2 gclk = ~gclk;
   end

   // Guard against a stuck run
   initial begin
      #20000;
      $display("Run went past its time limit");
      $display(">>> FAIL");
      $finish;
   end

   // Registered read with the address taken at the edge
   always @(posedge gclk) begin
      if (instEn) instData <= #1 memWords[instAddr[9:2]];
   end

   // Random word often forced to an interesting opcode
   function automatic logic [31:0] randomWord();
      logic [31:0] w;
      w = $random(seed);
      case ($random(seed) & 15)
         0: w[31:26] = 6'o54;
         1: w[31:26] = 6'o56;
         2: w[31:26] = 6'o47;
         3: w[31:26] = 6'o20;
         4: w[31:26] = 6'o60;
         5: w[31:26] = 6'o64;
         6: w[31:26] = 6'o55;
         7: w[31:26] = 6'o31;
         8: w[31:26] = 6'o30;
         default: ;
      endcase
      return w;
   endfunction

   task automatic nextCycle();
      @(posedge gclk);
      #1;
   endtask

   // Enable and branch strobe drawn fresh each cycle
   task automatic driveCycles(input integer n, input logic randEna, input logic randBranch);
      repeat (n) begin
         nextCycle();
         gena         = randEna ? (($random(seed) & 3) != 0) : 1'b1;
         branchTaken  = randBranch && (($random(seed) & 7) == 0);
         branchTarget = $random(seed) & 32'hFFFF_FFFC;
      end
   endtask

   initial begin
      grst         = 1'b1;
      gena         = 1'b0;
      oena         = 1'b1;
      intReq       = 1'b0;
      msrIe        = 1'b0;
      branchTaken  = 1'b0;
      branchTarget = 32'h0;
      instData     = 32'h0;
      for (int i = 0; i < 256; i++) memWords[i] = randomWord();
      repeat (5) @(posedge gclk);
      #1;
      grst = 1'b0;
      gena = 1'b1;

      driveCycles(60, 1'b0, 1'b0);
      check_i.endTest("fieldDecode");

      snap = check_i.immSeen;
      driveCycles(60, 1'b0, 1'b0);
      if (check_i.immSeen == snap) check_i.noteFailure("no IMM prefix reached decode");
      check_i.endTest("immPrefix");

      // Hold the request until the latch is set
      msrIe  = 1'b1;
      intReq = 1'b1;
      count  = 0;
      while (!check_i.latchSet && count < 20) begin
         nextCycle();
         count++;
      end
      if (!check_i.latchSet) check_i.noteFailure("interrupt latch did not set in time");
      intReq = 1'b0;
      snap   = check_i.intSeen;
      count  = 0;
      while (check_i.intSeen == snap && count < 40) begin
         nextCycle();
         count++;
      end
      if (check_i.intSeen == snap) check_i.noteFailure("no interrupt vector was inserted");
      driveCycles(10, 1'b0, 1'b0);
      msrIe = 1'b0;
      // Edge that clears the latch may still insert
      nextCycle();
      // Vectors already in the pipe leave decode within two enabled edges
      driveCycles(2, 1'b0, 1'b0);
      snap = check_i.intOut;
      driveCycles(40, 1'b0, 1'b0);
      if (check_i.intOut != snap) begin
         check_i.noteFailure("vector reached decode with interrupts off");
      end
      check_i.endTest("interrupt");

      oena = 1'b0;
      snap = check_i.stallSeen;
      driveCycles(80, 1'b0, 1'b0);
      if (check_i.stallSeen == snap) check_i.noteFailure("stall was never raised");
      oena = 1'b1;
      driveCycles(20, 1'b0, 1'b0);
      check_i.endTest("stall");

      driveCycles(100, 1'b1, 1'b0);
      check_i.endTest("enableHold");

      driveCycles(100, 1'b0, 1'b1);
      check_i.endTest("branch");

      $display("tests 6, checks %0d, errors %0d", check_i.checkCount, check_i.errCount);
      if (check_i.errCount == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
common/isaPkg.sv
common/pipePkg.sv
design/fetchUnit.sv
instBuffer/instBuffer.sv
design/opDecode.sv
design/frontEnd.sv
test/frontEndChecker.sv
test/frontEndTb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - common/isaPkg.sv
  - common/pipePkg.sv
  - design/fetchUnit.sv
  - instBuffer/instBuffer.sv
  - design/opDecode.sv
  - design/frontEnd.sv
  - target: test
    files:
      - test/frontEndChecker.sv
      - test/frontEndTb.sv
